/* files.f */
+incdir+verilog
+incdir+tb
verilog/corePkg.sv
verilog/aluUnit.sv
verilog/mulDivUnit.sv
verilog/operandSelect.sv
verilog/executeStage.sv
tb/executeStage_tb.sv

/* Makefile */
# Verilator build and run of the execute stage testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := executeStage_tb
FILELIST  := files.f
OBJDIR    := obj_dir
PASS_MSG  := Everything OK

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

# the run passes only if the pass message shows up in the output
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

/* tb/executeModel.svh */
/*
 * Reference model of the execute stage, included inside the testbench module.
 * It reads the stimulus signals of the testbench directly.
 */

`ifndef EXECUTE_MODEL_SVH
`define EXECUTE_MODEL_SVH

// expected contents of the E/M register
opcode_t  expOpcodeM;
iclass_t  expIclassM;
word_t    expPcM;
exc_t     expExcM;
word_t    expDataRtM;
word_t    expAluOutM;
logic     expRegWEnM;
regAddr_t expRegWAddrM;
word_t    expRegWDataM;

// MDU state, mdLeft is the number of edges until HI/LO are written
word_t   expHi;
word_t   expLo;
int      mdLeft;
opcode_t mdOp;
word_t   mdA;
word_t   mdB;

task automatic clearStage();
    expOpcodeM = NOP;
    expIclassM = NONE;
    expPcM = '0;
    expExcM = EXC_NONE;
    expDataRtM = '0;
    expAluOutM = '0;
    expRegWEnM = 1'b0;
    expRegWAddrM = '0;
    expRegWDataM = '0;
endtask

task automatic resetModel();
    clearStage();
    expHi = '0;
    expLo = '0;
    mdLeft = 0;
    mdOp = NOP;
    mdA = '0;
    mdB = '0;
endtask

// M first, then W, never register 0
function automatic word_t fwdValue(input regAddr_t addr, input word_t regData);
    if (expRegWEnM && expRegWAddrM != 0 && expRegWAddrM == addr) begin
        return expRegWDataM;
    end
    if (regWEnW && regWAddrW != 0 && regWAddrW == addr) begin
        return regWDataW;
    end
    return regData;
endfunction

function automatic word_t modelSrcA();
    if (opcodeE == SLL || opcodeE == SRL || opcodeE == SRA) begin
        return shamtE;
    end
    return fwdValue(addrRsE, dataRsE);
endfunction

function automatic word_t modelSrcB();
    if (iclassE == ALU_I || iclassE == MEM_R || iclassE == MEM_W) begin
        return extImmE;
    end
    return fwdValue(addrRtE, dataRtE);
endfunction

function automatic word_t leadingCount(input word_t v, input logic b);
    int n;
    n = 0;
    while (n < 32 && v[31 - n] == b) begin
        n++;
    end
    return word_t'(n);
endfunction

function automatic word_t aluModel(input opcode_t op, input iclass_t cls,
                                   input word_t a, input word_t b);
    word_t mask;
    mask = (word_t'(1) << `ADDR_MASK_BITS) - 1;
    if (cls == MEM_R || cls == MEM_W) begin
        return (a + b) & mask;
    end
    case (op)
        ADD, ADDU, ADDI, ADDIU: return a + b;
        SUB, SUBU:              return a - b;
        AND, ANDI:              return a & b;
        OR, ORI:                return a | b;
        XOR, XORI:              return a ^ b;
        NOR:                    return ~(a | b);
        LUI:                    return b;
        SLT, SLTI:              return {31'b0, $signed(a) < $signed(b)};
        SLTU, SLTIU:            return {31'b0, a < b};
        SLL, SLLV:              return b << a[4:0];
        SRL, SRLV:              return b >> a[4:0];
        SRA, SRAV:              return $signed(b) >>> a[4:0];
        CLO:                    return leadingCount(a, 1'b1);
        CLZ:                    return leadingCount(a, 1'b0);
        default:                return '0;
    endcase
endfunction

function automatic exc_t excModel(input opcode_t op, input iclass_t cls,
                                  input word_t a, input word_t b);
    word_t sum;
    word_t dif;
    logic sumOv;
    logic difOv;
    sum = a + b;
    dif = a - b;
    // overflow when the result sign differs from what the operands allow
    sumOv = (a[31] == b[31]) && (sum[31] != a[31]);
    difOv = (a[31] != b[31]) && (dif[31] != a[31]);
    if (sumOv && cls == MEM_R) begin
        return EXC_ADEL;
    end
    if (sumOv && cls == MEM_W) begin
        return EXC_ADES;
    end
    if (sumOv && (op == ADD || op == ADDI)) begin
        return EXC_OV;
    end
    if (difOv && op == SUB) begin
        return EXC_OV;
    end
    return EXC_NONE;
endfunction

function automatic logic mdStarts();
    logic isMul;
    logic isDiv;
    isMul = opcodeE inside {MULT, MULTU, MADD, MADDU, MSUB, MSUBU};
    isDiv = (opcodeE == DIV || opcodeE == DIVU) && modelSrcB() != 0;
    return mdEn && (isMul || isDiv) && mdLeft == 0;
endfunction

function automatic logic modelBusy();
    return mdLeft > 0 || mdStarts();
endfunction

task automatic finishMd();
    logic sgn;
    dword_t prod;
    sgn = !(mdOp inside {MULTU, MADDU, MSUBU, DIVU});
    if (sgn) begin
        prod = $signed({{32{mdA[31]}}, mdA}) * $signed({{32{mdB[31]}}, mdB});
    end else begin
        prod = {32'b0, mdA} * {32'b0, mdB};
    end
    case (mdOp)
        MULT, MULTU: {expHi, expLo} = prod;
        MADD, MADDU: {expHi, expLo} = {expHi, expLo} + prod;
        MSUB, MSUBU: {expHi, expLo} = {expHi, expLo} - prod;
        DIV: begin
            expHi = word_t'($signed(mdA) % $signed(mdB));
            expLo = word_t'($signed(mdA) / $signed(mdB));
        end
        DIVU: begin
            expHi = mdA % mdB;
            expLo = mdA / mdB;
        end
        default: begin
        end
    endcase
endtask

// one rising edge of the model
task automatic modelStep();
    word_t a;
    word_t b;
    word_t rt;
    word_t wdata;
    exc_t exc;
    a = modelSrcA();
    b = modelSrcB();
    rt = fwdValue(addrRtE, dataRtE);
    // write data sees HI/LO from before this edge
    if (opcodeE == MFHI) begin
        wdata = expHi;
    end else if (opcodeE == MFLO) begin
        wdata = expLo;
    end else if (iclassE == ALU_R || iclassE == ALU_I) begin
        wdata = aluModel(opcodeE, iclassE, a, b);
    end else begin
        wdata = regWDataE;
    end
    exc = (excE != EXC_NONE) ? excE : excModel(opcodeE, iclassE, a, b);

    if (mdLeft > 0) begin
        mdLeft--;
        if (mdLeft == 0) begin
            finishMd();
        end
    end else if (mdStarts()) begin
        mdOp = opcodeE;
        mdA = a;
        mdB = b;
        mdLeft = (opcodeE == DIV || opcodeE == DIVU) ? `DIV_DELAY : `MULT_DELAY;
    end else if (opcodeE == MTHI) begin
        expHi = a;
    end else if (opcodeE == MTLO) begin
        expLo = a;
    end

    // stall holds, clear without stall makes a bubble
    if (clear && !stall) begin
        clearStage();
    end else if (!stall) begin
        expOpcodeM = opcodeE;
        expIclassM = iclassE;
        expPcM = pcE;
        expExcM = exc;
        expDataRtM = rt;
        expAluOutM = aluModel(opcodeE, iclassE, a, b);
        expRegWEnM = regWEnE;
        expRegWAddrM = regWAddrE;
        expRegWDataM = wdata;
    end
endtask

`endif

/* tb/executeStage_tb.sv */
/*
 * Random testbench for the execute stage, checked each cycle against the
 * model in executeModel.svh. Runs stop at the first mismatch.
 */

`timescale 1ns/1ps

`include "coreParams.svh"

module executeStage_tb;
    import corePkg::*;

    localparam int PERIOD = 40;
    localparam int NUM_TRANS = 3000;
    localparam logic [31:0] SEED = 32'ha2cf_c4e0;
    localparam longint WATCHDOG_NS = longint'(NUM_TRANS + 8) * (`DIV_DELAY + 4) * PERIOD;

    logic     clk;
    logic     reset;
    opcode_t  opcodeE;
    iclass_t  iclassE;
    word_t    pcE;
    exc_t     excE;
    regAddr_t addrRsE;
    regAddr_t addrRtE;
    word_t    dataRsE;
    word_t    dataRtE;
    word_t    extImmE;
    word_t    shamtE;
    logic     regWEnE;
    regAddr_t regWAddrE;
    word_t    regWDataE;
    logic     regWEnW;
    regAddr_t regWAddrW;
    word_t    regWDataW;
    logic     stall;
    logic     clear;
    logic     mdEn;
    opcode_t  opcodeM;
    iclass_t  iclassM;
    word_t    pcM;
    exc_t     excM;
    word_t    dataRtM;
    word_t    aluOutM;
    logic     regWEnM;
    regAddr_t regWAddrM;
    word_t    regWDataM;
    logic     mdBusy;

    executeStage executeStage_inst (.*);

    `include "executeModel.svh"

    always #(PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // failure reporting and compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic valueMismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        abortRun($sformatf("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp));
    endtask

    task automatic checkWord(input string name, input word_t got, input word_t exp);
        if (got !== exp) valueMismatch(name, 64'(got), 64'(exp));
    endtask

    task automatic checkExc(input string name, input exc_t got, input exc_t exp);
        if (got !== exp) valueMismatch(name, 64'(got), 64'(exp));
    endtask

    task automatic checkAddr(input string name, input regAddr_t got, input regAddr_t exp);
        if (got !== exp) valueMismatch(name, 64'(got), 64'(exp));
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) valueMismatch(name, 64'(got), 64'(exp));
    endtask

    task automatic checkOpcode(input string name, input opcode_t got, input opcode_t exp);
        if (got !== exp) valueMismatch(name, 64'(got), 64'(exp));
    endtask

    task automatic checkClass(input string name, input iclass_t got, input iclass_t exp);
        if (got !== exp) valueMismatch(name, 64'(got), 64'(exp));
    endtask

    task automatic compareStage();
        checkOpcode("opcodeM", opcodeM, expOpcodeM);
        checkClass("iclassM", iclassM, expIclassM);
        checkWord("pcM", pcM, expPcM);
        checkExc("excM", excM, expExcM);
        checkWord("dataRtM", dataRtM, expDataRtM);
        checkWord("aluOutM", aluOutM, expAluOutM);
        checkBit("regWEnM", regWEnM, expRegWEnM);
        checkAddr("regWAddrM", regWAddrM, expRegWAddrM);
        checkWord("regWDataM", regWDataM, expRegWDataM);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    function automatic iclass_t classOf(input opcode_t op);
        case (op)
            NOP:                                            return NONE;
            ADDI, ADDIU, ANDI, ORI, XORI, LUI, SLTI, SLTIU: return ALU_I;
            LW:                                             return MEM_R;
            SW:                                             return MEM_W;
            MULT, MULTU, DIV, DIVU, MADD, MADDU, MSUB, MSUBU,
            MTHI, MTLO, MFHI, MFLO:                         return MD;
            default:                                        return ALU_R;
        endcase
    endfunction

    // edge values often, so that overflow and divide by zero show up
    function automatic word_t randomData();
        case ($urandom_range(0, 7))
            0:       return 32'h0000_0000;
            1:       return 32'h7fff_ffff;
            2:       return 32'h8000_0000;
            3:       return word_t'($urandom_range(0, 15));
            default: return $urandom;
        endcase
    endfunction

    function automatic exc_t pickExc();
        case ($urandom_range(0, 3))
            0:       return EXC_ADEL;
            1:       return EXC_ADES;
            2:       return EXC_OV;
            default: return EXC_RI;
        endcase
    endfunction

    task automatic driveRandom();
        logic [15:0] imm;
        imm = 16'($urandom);
        opcodeE = opcode_t'($urandom_range(0, 40));
        iclassE = classOf(opcodeE);
        pcE = $urandom & 32'hffff_fffc;
        excE = ($urandom_range(0, 7) == 0) ? pickExc() : EXC_NONE;
        // few register numbers so forwarding hits often
        addrRsE = regAddr_t'($urandom_range(0, 3));
        addrRtE = regAddr_t'($urandom_range(0, 3));
        dataRsE = randomData();
        dataRtE = randomData();
        extImmE = {{16{imm[15]}}, imm};
        shamtE = word_t'($urandom_range(0, 31));
        regWEnE = 1'($urandom);
        regWAddrE = regAddr_t'($urandom_range(0, 3));
        regWDataE = $urandom;
        regWEnW = 1'($urandom);
        regWAddrW = regAddr_t'($urandom_range(0, 3));
        regWDataW = randomData();
        stall = ($urandom_range(0, 7) == 0);
        clear = ($urandom_range(0, 7) == 0);
        mdEn = ($urandom_range(0, 3) != 0);
        // the one signed quotient that does not fit is left out
        if (opcodeE == DIV && modelSrcA() == 32'h8000_0000 && modelSrcB() == 32'hffff_ffff) begin
            opcodeE = DIVU;
        end
    endtask

    task automatic initInputs();
        clk = 1'b0;
        reset = 1'b1;
        opcodeE = NOP;
        iclassE = NONE;
        pcE = '0;
        excE = EXC_NONE;
        addrRsE = '0;
        addrRtE = '0;
        dataRsE = '0;
        dataRtE = '0;
        extImmE = '0;
        shamtE = '0;
        regWEnE = 1'b0;
        regWAddrE = '0;
        regWDataE = '0;
        regWEnW = 1'b0;
        regWAddrW = '0;
        regWDataW = '0;
        stall = 1'b0;
        clear = 1'b0;
        mdEn = 1'b0;
    endtask

    initial begin
        #(WATCHDOG_NS);
        abortRun("timeout: the testbench did not finish in the expected time");
    end

    initial begin
        void'($urandom(SEED));
        initInputs();
        resetModel();
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        // register is a bubble and the MDU is idle right after reset
        compareStage();
        checkBit("mdBusy", mdBusy, 1'b0);

        repeat (NUM_TRANS) begin
            driveRandom();
            #1;
            checkBit("mdBusy", mdBusy, modelBusy());
            @(posedge clk);
            modelStep();
            @(negedge clk);
            compareStage();
        end

        $display("Everything OK");
        $finish;
    end

endmodule

/* verilog/executeStage.sv */
/*
 * Execute stage with its E/M pipeline register. stall beats clear, and
 * a cleared register is a bubble. mdEn is gated by the pipeline controller.
 */

`timescale 1ns/1ps

`include "coreParams.svh"

module executeStage (
    input  logic              clk,
    input  logic              reset,
    input  corePkg::opcode_t  opcodeE,
    input  corePkg::iclass_t  iclassE,
    input  corePkg::word_t    pcE,
    input  corePkg::exc_t     excE,
    input  corePkg::regAddr_t addrRsE,
    input  corePkg::regAddr_t addrRtE,
    input  corePkg::word_t    dataRsE,
    input  corePkg::word_t    dataRtE,
    input  corePkg::word_t    extImmE,
    input  corePkg::word_t    shamtE,
    input  logic              regWEnE,
    input  corePkg::regAddr_t regWAddrE,
    input  corePkg::word_t    regWDataE,
    input  logic              regWEnW,
    input  corePkg::regAddr_t regWAddrW,
    input  corePkg::word_t    regWDataW,
    input  logic              stall,
    input  logic              clear,
    input  logic              mdEn,
    output corePkg::opcode_t  opcodeM,
    output corePkg::iclass_t  iclassM,
    output corePkg::word_t    pcM,
    output corePkg::exc_t     excM,
    output corePkg::word_t    dataRtM,
    output corePkg::word_t    aluOutM,
    output logic              regWEnM,
    output corePkg::regAddr_t regWAddrM,
    output corePkg::word_t    regWDataM,
    output logic              mdBusy
);
    import corePkg::*;

    word_t srcA;
    word_t srcB;
    word_t rtFwd;
    word_t aluOut;
    word_t hi;
    word_t lo;
    word_t regWData;
    exc_t aluExc;
    exc_t excSel;

    // the M register outputs are the M forwarding source
    operandSelect operandSelect_inst (
        .opcode(opcodeE), .iclass(iclassE),
        .addrRs(addrRsE), .addrRt(addrRtE),
        .dataRs(dataRsE), .dataRt(dataRtE),
        .extImm(extImmE), .shamt(shamtE),
        .fwdEnM(regWEnM), .fwdAddrM(regWAddrM), .fwdDataM(regWDataM),
        .fwdEnW(regWEnW), .fwdAddrW(regWAddrW), .fwdDataW(regWDataW),
        .srcA(srcA), .srcB(srcB), .rtFwd(rtFwd)
    );

    aluUnit aluUnit_inst (
        .opcode(opcodeE), .iclass(iclassE),
        .srcA(srcA), .srcB(srcB),
        .result(aluOut), .exc(aluExc)
    );

    mulDivUnit mulDivUnit_inst (
        .clk(clk), .reset(reset),
        .opcode(opcodeE), .en(mdEn),
        .srcA(srcA), .srcB(srcB),
        .hi(hi), .lo(lo), .busy(mdBusy)
    );

    always_comb begin
        if (opcodeE == MFHI) begin
            regWData = hi;
        end else if (opcodeE == MFLO) begin
            regWData = lo;
        end else if (iclassE == ALU_R || iclassE == ALU_I) begin
            regWData = aluOut;
        end else begin
            regWData = regWDataE;
        end
    end

    // an earlier exception from upstream takes precedence
    assign excSel = (excE != EXC_NONE) ? excE : aluExc;

    ////////////////////////////////////////////////////////////////////////////
    // E/M pipeline register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset || (clear && !stall)) begin
            opcodeM <= NOP;
            iclassM <= NONE;
            pcM <= '0;
            excM <= EXC_NONE;
            dataRtM <= '0;
            aluOutM <= '0;
            regWEnM <= 1'b0;
            regWAddrM <= '0;
            regWDataM <= '0;
        end else if (!stall) begin
            opcodeM <= opcodeE;
            iclassM <= iclassE;
            pcM <= pcE;
            excM <= excSel;
            dataRtM <= rtFwd;
            aluOutM <= aluOut;
            regWEnM <= regWEnE;
            regWAddrM <= regWAddrE;
            regWDataM <= regWData;
        end
    end

    // a memory access reaches M with an address inside the data memory
    assert property (@(posedge clk) disable iff (reset)
        (iclassM inside {MEM_R, MEM_W}) |-> (aluOutM[`WORD_WIDTH-1:`ADDR_MASK_BITS] == '0));

endmodule

/* verilog/operandSelect.sv */
/*
 * Forwarding from the M and W stages and ALU operand selection.
 * M has priority over W; register 0 is never forwarded.
 */

`timescale 1ns/1ps

module operandSelect (
    input  corePkg::opcode_t opcode,
    input  corePkg::iclass_t iclass,
    input  corePkg::regAddr_t addrRs,
    input  corePkg::regAddr_t addrRt,
    input  corePkg::word_t   dataRs,
    input  corePkg::word_t   dataRt,
    input  corePkg::word_t   extImm,
    input  corePkg::word_t   shamt,
    input  logic             fwdEnM,
    input  corePkg::regAddr_t fwdAddrM,
    input  corePkg::word_t   fwdDataM,
    input  logic             fwdEnW,
    input  corePkg::regAddr_t fwdAddrW,
    input  corePkg::word_t   fwdDataW,
    output corePkg::word_t   srcA,
    output corePkg::word_t   srcB,
    output corePkg::word_t   rtFwd
);
    import corePkg::*;

    word_t rsFwd;

    function automatic word_t forward(input regAddr_t addr, input word_t regData);
        if (fwdEnM && fwdAddrM != '0 && fwdAddrM == addr) begin
            return fwdDataM;
        end else if (fwdEnW && fwdAddrW != '0 && fwdAddrW == addr) begin
            return fwdDataW;
        end
        return regData;
    endfunction

    always_comb begin
        rsFwd = forward(addrRs, dataRs);
        rtFwd = forward(addrRt, dataRt);
    end

    // constant shifts take shamt, immediate forms take extImm
    assign srcA = (opcode inside {SLL, SRL, SRA}) ? shamt : rsFwd;
    assign srcB = (iclass inside {ALU_I, MEM_R, MEM_W}) ? extImm : rtFwd;

endmodule

/* verilog/mulDivUnit.sv */
/*
 * Behavioural multiply/divide with fixed latency, not meant for synthesis.
 * A divide by zero is ignored. MTHI/MTLO are taken only while idle.
 */

`timescale 1ns/1ps

`include "coreParams.svh"

module mulDivUnit (
    input  logic             clk,
    input  logic             reset,
    input  corePkg::opcode_t opcode,
    input  logic             en,
    input  corePkg::word_t   srcA,
    input  corePkg::word_t   srcB,
    output corePkg::word_t   hi,
    output corePkg::word_t   lo,
    output logic             busy
);
    import corePkg::*;

    localparam int CNT_W = $clog2(`DIV_DELAY + 1);

    typedef enum logic {
        IDLE,
        RUN
    } mdState_t;

    mdState_t state;
    logic [CNT_W-1:0] count;

    // operands and opcode held for the whole operation
    opcode_t opReg;
    word_t opA;
    word_t opB;

    logic isMul;
    logic isDiv;
    logic start;
    logic isSigned;
    logic signed [2*`WORD_WIDTH-1:0] prodSigned;
    dword_t prodUnsigned;
    dword_t product;
    dword_t hiLo;
    word_t quotient;
    word_t remainder;

    assign isMul = opcode inside {MULT, MULTU, MADD, MADDU, MSUB, MSUBU};
    assign isDiv = (opcode inside {DIV, DIVU}) && (srcB != '0);
    assign start = en && (isMul || isDiv) && (state == IDLE);

    // high already in the start cycle so the controller can stall at once
    assign busy = (state == RUN) || start;

    ////////////////////////////////////////////////////////////////////////////
    // arithmetic on the held operands
    ////////////////////////////////////////////////////////////////////////////

    assign isSigned = !(opReg inside {MULTU, MADDU, MSUBU, DIVU});
    assign prodSigned = $signed(opA) * $signed(opB);
    assign prodUnsigned = opA * opB;
    assign product = isSigned ? dword_t'(prodSigned) : prodUnsigned;
    assign hiLo = {hi, lo};

    assign quotient = isSigned ? word_t'($signed(opA) / $signed(opB)) : opA / opB;
    assign remainder = isSigned ? word_t'($signed(opA) % $signed(opB)) : opA % opB;

    always_ff @(posedge clk) begin
        if (start) begin
            opReg <= opcode;
            opA <= srcA;
            opB <= srcB;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // latency counter and HI/LO update
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
            count <= '0;
            hi <= '0;
            lo <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state <= RUN;
                        count <= isDiv ? CNT_W'(`DIV_DELAY) : CNT_W'(`MULT_DELAY);
                    end else if (opcode == MTHI) begin
                        hi <= srcA;
                    end else if (opcode == MTLO) begin
                        lo <= srcA;
                    end
                end
                RUN: begin
                    if (count == CNT_W'(1)) begin
                        // last cycle, result lands together with busy falling
                        state <= IDLE;
                        count <= '0;
                        case (opReg)
                            MULT, MULTU: {hi, lo} <= product;
                            MADD, MADDU: {hi, lo} <= hiLo + product;
                            MSUB, MSUBU: {hi, lo} <= hiLo - product;
                            DIV, DIVU: begin
                                hi <= remainder;
                                lo <= quotient;
                            end
                            default: begin
                            end
                        endcase
                    end else begin
                        count <= count - 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // a new start only once the previous operation has written back
    assert property (@(posedge clk) disable iff (reset)
        start |-> !$past(busy) || ($past(state) == RUN && $past(count) == CNT_W'(1)));

    // busy stays high through RUN and drops only with the write
    assert property (@(posedge clk) disable iff (reset)
        $fell(busy) |-> ($past(state) == RUN && $past(count) == CNT_W'(1)));

endmodule

/* verilog/aluUnit.sv */
/*
 * Combinational ALU. Memory classes produce a masked effective address.
 * Only signed add/sub overflow is detected; alignment is not checked here.
 */

`timescale 1ns/1ps

`include "coreParams.svh"

module aluUnit (
    input  corePkg::opcode_t opcode,
    input  corePkg::iclass_t iclass,
    input  corePkg::word_t   srcA,
    input  corePkg::word_t   srcB,
    output corePkg::word_t   result,
    output corePkg::exc_t    exc
);
    import corePkg::*;

    localparam int W = $bits(word_t);
    localparam word_t ADDR_MASK = word_t'({`ADDR_MASK_BITS{1'b1}});

    typedef enum logic [3:0] {
        OP_ZERO, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_NOR, OP_PASSB,
        OP_SLT, OP_SLTU, OP_SLL, OP_SRL, OP_SRA, OP_CLO, OP_CLZ, OP_ADDR
    } aluOp_t;

    aluOp_t aluOp;
    logic isMem;
    logic [W:0] sumExt;
    logic [W:0] difExt;
    logic sumOvf;
    logic difOvf;

    function automatic word_t countLeading(input word_t value, input logic bitVal);
        word_t count;
        logic done;
        count = '0;
        done = 1'b0;
        for (int i = W - 1; i >= 0; i--) begin
            if (!done && value[i] == bitVal) begin
                count = count + 1'b1;
            end else begin
                done = 1'b1;
            end
        end
        return count;
    endfunction

    assign isMem = (iclass == MEM_R) || (iclass == MEM_W);

    ////////////////////////////////////////////////////////////////////////////
    // opcode decode
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        if (isMem) begin
            aluOp = OP_ADDR;
        end else begin
            case (opcode)
                ADD, ADDU, ADDI, ADDIU: aluOp = OP_ADD;
                SUB, SUBU:              aluOp = OP_SUB;
                AND, ANDI:              aluOp = OP_AND;
                OR, ORI:                aluOp = OP_OR;
                XOR, XORI:              aluOp = OP_XOR;
                NOR:                    aluOp = OP_NOR;
                LUI:                    aluOp = OP_PASSB;
                SLT, SLTI:              aluOp = OP_SLT;
                SLTU, SLTIU:            aluOp = OP_SLTU;
                SLL, SLLV:              aluOp = OP_SLL;
                SRL, SRLV:              aluOp = OP_SRL;
                SRA, SRAV:              aluOp = OP_SRA;
                CLO:                    aluOp = OP_CLO;
                CLZ:                    aluOp = OP_CLZ;
                default:                aluOp = OP_ZERO;
            endcase
        end
    end

    // shift amount is srcA, the shifted value is srcB
    always_comb begin
        case (aluOp)
            OP_ADD:   result = srcA + srcB;
            OP_SUB:   result = srcA - srcB;
            OP_AND:   result = srcA & srcB;
            OP_OR:    result = srcA | srcB;
            OP_XOR:   result = srcA ^ srcB;
            OP_NOR:   result = ~(srcA | srcB);
            OP_PASSB: result = srcB;
            OP_SLT:   result = word_t'($signed(srcA) < $signed(srcB));
            OP_SLTU:  result = word_t'(srcA < srcB);
            OP_SLL:   result = srcB << srcA[4:0];
            OP_SRL:   result = srcB >> srcA[4:0];
            OP_SRA:   result = word_t'($signed(srcB) >>> srcA[4:0]);
            OP_CLO:   result = countLeading(srcA, 1'b1);
            OP_CLZ:   result = countLeading(srcA, 1'b0);
            OP_ADDR:  result = (srcA + srcB) & ADDR_MASK;
            default:  result = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // overflow and exceptions
    ////////////////////////////////////////////////////////////////////////////

    assign sumExt = {srcA[W-1], srcA} + {srcB[W-1], srcB};
    assign difExt = {srcA[W-1], srcA} - {srcB[W-1], srcB};
    assign sumOvf = sumExt[W] ^ sumExt[W-1];
    assign difOvf = difExt[W] ^ difExt[W-1];

    always_comb begin
        if (iclass == MEM_R && sumOvf) begin
            exc = EXC_ADEL;
        end else if (iclass == MEM_W && sumOvf) begin
            exc = EXC_ADES;
        end else if ((opcode == ADD || opcode == ADDI) && sumOvf) begin
            exc = EXC_OV;
        end else if (opcode == SUB && difOvf) begin
            exc = EXC_OV;
        end else begin
            exc = EXC_NONE;
        end
    end

    always_comb begin
        if (!$isunknown({opcode, iclass, srcA, srcB})) begin
            assert (!$isunknown(exc))
                else $error("aluUnit: exc unknown with known inputs");
        end
    end

endmodule

/* verilog/corePkg.sv */
/*
 * Types shared by the execute stage. Opcodes and classes come from decode.
 * NOP, NONE and EXC_NONE are zero so that a cleared register is a bubble.
 */

`include "coreParams.svh"

package corePkg;

    typedef logic [`WORD_WIDTH-1:0]     word_t;
    typedef logic [2*`WORD_WIDTH-1:0]   dword_t;
    // register 0 always reads as zero
    typedef logic [`REG_ADDR_WIDTH-1:0] regAddr_t;

    typedef enum logic [5:0] {
        NOP = 6'd0,
        ADD, ADDU, ADDI, ADDIU, SUB, SUBU,
        AND, ANDI, OR, ORI, XOR, XORI, NOR, LUI,
        SLT, SLTI, SLTU, SLTIU,
        SLL, SRL, SRA, SLLV, SRLV, SRAV,
        CLO, CLZ,
        LW, SW,
        MULT, MULTU, DIV, DIVU,
        MADD, MADDU, MSUB, MSUBU,
        MTHI, MTLO, MFHI, MFLO
    } opcode_t;

    typedef enum logic [2:0] {
        NONE  = 3'd0,
        ALU_R,
        ALU_I,
        MEM_R,
        MEM_W,
        MD
    } iclass_t;

    // cause codes as in the MIPS cause register
    typedef enum logic [4:0] {
        EXC_NONE = 5'd0,
        EXC_ADEL = 5'd4,
        EXC_ADES = 5'd5,
        EXC_OV   = 5'd12,
        EXC_RI   = 5'd10
    } exc_t;

endpackage

/* verilog/coreParams.svh */
/*
 * Widths, MDU latencies and data address mask for the execute stage.
 * The delays must stay at 1 or more, and DIV_DELAY must be the larger one.
 */

`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// datapath widths
////////////////////////////////////////////////////////////////////////////

`define WORD_WIDTH 32
`define REG_ADDR_WIDTH 5

////////////////////////////////////////////////////////////////////////////
// multiply/divide latency in cycles
////////////////////////////////////////////////////////////////////////////

`define MULT_DELAY 5
`define DIV_DELAY 10

// data memory is small, only the low bits of an address are kept
`define ADDR_MASK_BITS 14

`endif
